/* include/mbox_config.svh */
/*
 Build constants for the link transmitter: word width, FIFO depth and
 the APB register map. Include this wherever one of the macros is used.
 */
`ifndef MBOX_CONFIG_SVH
`define MBOX_CONFIG_SVH

// Datapath sizes
`define MBOX_DW 16              // Link and FIFO word width
`define MBOX_AW 5               // FIFO address bits for 32 entries

// APB byte offsets
`define MBOX_REG_DATA   8'h00   // Write pushes one word
`define MBOX_REG_CTRL   8'h04   // Write starts a burst
`define MBOX_REG_STATUS 8'h08   // Read returns the flags

`endif

/* hdl/mbox_pkg.sv */
/*
 Types shared by the link transmitter blocks.
 Compile ahead of the RTL that imports it.
 */
`include "mbox_config.svh"

package mbox_pkg;

   // Word presented on the link port
   typedef struct packed {
      logic [`MBOX_DW-1:0] data;   // Payload popped from the FIFO
      logic                last;   // Set on the final word of a burst
   } link_word_t;

   // Start command from the register block
   typedef struct packed {
      logic [5:0] len;             // Words in burst 1 to 32
      logic [7:0] gap;             // Idle cycles between words
   } burst_cmd_t;

   // Sequencer states
   typedef enum logic [1:0] {
      ST_IDLE,                     // No burst running
      ST_FETCH,                    // Pop as soon as FIFO has data
      ST_SEND,                     // Hold word until ready
      ST_GAP                       // Idle between words
   } tx_state_t;

   // STATUS read value in prdata[2:0]
   typedef struct packed {
      logic fifo_empty;            // Bit 2
      logic fifo_full;             // Bit 1
      logic busy;                  // Bit 0
   } mbox_status_t;

endpackage

/* hdl/fifo_sync.sv */
/*
 Small synchronous FIFO with registered empty/full flags and an inferred
 register array. There is no overflow or underflow guard, so the writer must
 not push when full and the reader must not pop when empty.
 */
`include "mbox_config.svh"

module fifo_sync #(
   parameter int AW = `MBOX_AW,                  // Depth is 2**AW
   parameter int DW = `MBOX_DW                   // Word width
) (
   input  logic          clk,
   input  logic          reset,
   input  logic [DW-1:0] wr_data,
   input  logic          wr_en,
   input  logic          rd_en,
   output logic [DW-1:0] rd_data,
   output logic          rd_empty,
   output logic          wr_full
);

   logic [DW-1:0] mem [0:(1<<AW)-1];             // Storage array
   logic [AW-1:0] waddr;                         // Next slot to write
   logic [AW-1:0] raddr;                         // Oldest entry
   logic [AW-1:0] count;                         // Wraps to 0 when full

   // Pointers, occupancy and flags
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         waddr    <= '0;
         raddr    <= '0;
         count    <= '0;
         rd_empty <= 1'b1;
         wr_full  <= 1'b0;
      end
      else if (wr_en && rd_en)
      begin
         waddr <= waddr + 1'b1;                  // Occupancy unchanged
         raddr <= raddr + 1'b1;                  // Flags hold
      end
      else if (wr_en)
      begin
         waddr    <= waddr + 1'b1;
         count    <= count + 1'b1;
         rd_empty <= 1'b0;
         if (&count)                             // Last free slot taken
            wr_full <= 1'b1;
      end
      else if (rd_en)
      begin
         raddr   <= raddr + 1'b1;
         count   <= count - 1'b1;
         wr_full <= 1'b0;
         if (count == 1)                         // Final entry leaving
            rd_empty <= 1'b1;
      end
   end

   // Write port
   always_ff @(posedge clk)
   begin
      if (wr_en)
         mem[waddr] <= wr_data;
   end

   // Asynchronous read of the head entry
   assign rd_data = mem[raddr];

endmodule

/* hdl/mbox_regs.sv */
/*
 APB register block. DATA writes push one word into the FIFO, CTRL writes
 issue a one-cycle start with a held burst command, STATUS reads the flags.
 Illegal writes complete with pslverr and have no effect.
 */
`include "mbox_config.svh"

module mbox_regs (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 psel,
   input  logic                 penable,
   input  logic                 pwrite,
   input  logic [7:0]           paddr,
   input  logic [31:0]          pwdata,
   output logic [31:0]          prdata,
   output logic                 pready,
   output logic                 pslverr,
   output logic [`MBOX_DW-1:0]  fifo_wr_data,
   output logic                 fifo_wr_en,
   input  logic                 fifo_full,
   input  logic                 fifo_empty,
   input  logic                 busy,
   output logic                 start,
   output mbox_pkg::burst_cmd_t cmd
);
   import mbox_pkg::*;

   logic         access;                          // APB access phase
   logic         wr_data_sel;                     // DATA write
   logic         wr_ctrl_sel;                     // CTRL write
   logic         rd_status_sel;                   // STATUS read
   logic         len_bad;                         // Length outside 1 to 32
   logic         ctrl_refuse;                     // CTRL write not accepted
   burst_cmd_t   cmd_in;                          // Decoded CTRL word
   mbox_status_t status;

   assign access        = psel & penable;
   assign wr_data_sel   = access & pwrite & (paddr == `MBOX_REG_DATA);
   assign wr_ctrl_sel   = access & pwrite & (paddr == `MBOX_REG_CTRL);
   assign rd_status_sel = access & ~pwrite & (paddr == `MBOX_REG_STATUS);

   // CTRL field decode
   assign cmd_in.len = pwdata[5:0];
   assign cmd_in.gap = pwdata[15:8];
   assign len_bad    = (cmd_in.len == 6'd0) || (cmd_in.len > 6'd32);

   // A start still in flight counts as busy
   assign ctrl_refuse = busy | start | len_bad;

   // Guarded push lands on the access-phase edge
   assign fifo_wr_en   = wr_data_sel & ~fifo_full;
   assign fifo_wr_data = pwdata[`MBOX_DW-1:0];

   assign pready  = 1'b1;                         // No wait states
   assign pslverr = (wr_data_sel & fifo_full) | (wr_ctrl_sel & ctrl_refuse);

   // Status word
   assign status.fifo_empty = fifo_empty;
   assign status.fifo_full  = fifo_full;
   assign status.busy       = busy;

   // Read mux, DATA and unmapped read as zero
   always_comb
   begin
      prdata = '0;
      if (rd_status_sel)
         prdata[2:0] = status;
   end

   // One-cycle start pulse
   always_ff @(posedge clk)
   begin
      if (reset)
         start <= 1'b0;
      else
         start <= wr_ctrl_sel & ~ctrl_refuse;
   end

   // Command held until the next accepted CTRL write
   always_ff @(posedge clk)
   begin
      if (wr_ctrl_sel && !ctrl_refuse)
         cmd <= cmd_in;
   end

endmodule

/* hdl/tx_gap_timer.sv */
/*
 Inter-word idle timer. Load arms it with a gap count and expired pulses
 once the count has run down to zero. A gap of zero expires next cycle.
 */
module tx_gap_timer (
   input  logic       clk,
   input  logic       reset,
   input  logic       load,
   input  logic [7:0] gap,
   output logic       expired
);

   logic [7:0] count;                             // Cycles left
   logic       armed;                             // Timer running

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         count <= 8'd0;
         armed <= 1'b0;
      end
      else if (load)
      begin
         count <= gap;
         armed <= 1'b1;
      end
      else if (armed)
      begin
         if (count == 8'd0)
            armed <= 1'b0;                        // One-shot
         else
            count <= count - 8'd1;
      end
   end

   // Single-cycle pulse at zero
   assign expired = armed & (count == 8'd0);

endmodule

/* hdl/tx_sequencer.sv */
/*
 Burst sequencer. On start it pops len words from the FIFO one at a time,
 presents each on the valid/ready link port, marks the final one last and
 runs the gap timer between words. Never pops an empty FIFO.
 */
`include "mbox_config.svh"

module tx_sequencer (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 start,
   input  mbox_pkg::burst_cmd_t cmd,
   input  logic [`MBOX_DW-1:0]  fifo_rd_data,
   input  logic                 fifo_empty,
   output logic                 fifo_rd_en,
   output logic                 timer_load,
   output logic [7:0]           timer_gap,
   input  logic                 timer_expired,
   output mbox_pkg::link_word_t link,
   output logic                 link_valid,
   input  logic                 link_ready,
   output logic                 busy
);
   import mbox_pkg::*;

   tx_state_t  state;
   logic [5:0] remaining;                         // Words not yet popped
   logic [7:0] gap_r;                             // Gap of running burst
   logic       handshake;                         // Word accepted

   assign handshake  = link_valid & link_ready;
   assign fifo_rd_en = (state == ST_FETCH) & ~fifo_empty;
   assign timer_load = (state == ST_SEND) & handshake & ~link.last & (gap_r != 8'd0);
   assign timer_gap  = gap_r;
   assign busy       = (state != ST_IDLE);

   // FSM and valid
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state      <= ST_IDLE;
         remaining  <= 6'd0;
         link_valid <= 1'b0;
      end
      else
      begin
         case (state)
            ST_IDLE:
            begin
               if (start)
               begin
                  remaining <= cmd.len;
                  state     <= ST_FETCH;
               end
            end
            ST_FETCH:
            begin
               if (fifo_rd_en)                    // Waits here when starved
               begin
                  remaining  <= remaining - 6'd1;
                  link_valid <= 1'b1;
                  state      <= ST_SEND;
               end
            end
            ST_SEND:
            begin
               if (handshake)
               begin
                  link_valid <= 1'b0;
                  if (link.last)
                     state <= ST_IDLE;            // Burst done
                  else if (timer_load)
                     state <= ST_GAP;
                  else
                     state <= ST_FETCH;           // Zero gap
               end
            end
            ST_GAP:
            begin
               if (timer_expired)
                  state <= ST_FETCH;
            end
            default:
            begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

   // Burst gap and output word
   always_ff @(posedge clk)
   begin
      if (state == ST_IDLE && start)
         gap_r <= cmd.gap;
      if (fifo_rd_en)
      begin
         link.data <= fifo_rd_data;               // Held under back-pressure
         link.last <= (remaining == 6'd1);
      end
   end

endmodule

/* hdl/mbox_top.sv */
/*
 Link transmitter top level. APB programs the register block, which fills
 the FIFO and starts bursts that the sequencer sends on the link port.
 */
`include "mbox_config.svh"

module mbox_top (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 psel,
   input  logic                 penable,
   input  logic                 pwrite,
   input  logic [7:0]           paddr,
   input  logic [31:0]          pwdata,
   output logic [31:0]          prdata,
   output logic                 pready,
   output logic                 pslverr,
   output mbox_pkg::link_word_t link,
   output logic                 link_valid,
   input  logic                 link_ready
);
   import mbox_pkg::*;

   logic [`MBOX_DW-1:0] fifo_wr_data;             // Push path
   logic                fifo_wr_en;
   logic [`MBOX_DW-1:0] fifo_rd_data;             // Pop path
   logic                fifo_rd_en;
   logic                fifo_empty;
   logic                fifo_full;
   logic                busy;                     // Burst running
   logic                start;
   burst_cmd_t          cmd;
   logic                timer_load;
   logic [7:0]          timer_gap;
   logic                timer_expired;

   mbox_regs mbox_regs_i (
      .clk          (clk),
      .reset        (reset),
      .psel         (psel),
      .penable      (penable),
      .pwrite       (pwrite),
      .paddr        (paddr),
      .pwdata       (pwdata),
      .prdata       (prdata),
      .pready       (pready),
      .pslverr      (pslverr),
      .fifo_wr_data (fifo_wr_data),
      .fifo_wr_en   (fifo_wr_en),
      .fifo_full    (fifo_full),
      .fifo_empty   (fifo_empty),
      .busy         (busy),
      .start        (start),
      .cmd          (cmd)
   );

   fifo_sync #(
      .AW (`MBOX_AW),
      .DW (`MBOX_DW)
   ) fifo_sync_i (
      .clk      (clk),
      .reset    (reset),
      .wr_data  (fifo_wr_data),
      .wr_en    (fifo_wr_en),
      .rd_en    (fifo_rd_en),
      .rd_data  (fifo_rd_data),
      .rd_empty (fifo_empty),
      .wr_full  (fifo_full)
   );

   tx_sequencer tx_sequencer_i (
      .clk           (clk),
      .reset         (reset),
      .start         (start),
      .cmd           (cmd),
      .fifo_rd_data  (fifo_rd_data),
      .fifo_empty    (fifo_empty),
      .fifo_rd_en    (fifo_rd_en),
      .timer_load    (timer_load),
      .timer_gap     (timer_gap),
      .timer_expired (timer_expired),
      .link          (link),
      .link_valid    (link_valid),
      .link_ready    (link_ready),
      .busy          (busy)
   );

   tx_gap_timer tx_gap_timer_i (
      .clk     (clk),
      .reset   (reset),
      .load    (timer_load),
      .gap     (timer_gap),
      .expired (timer_expired)
   );

endmodule

/* bench/clk_gen.sv */
/*
 Testbench clock and reset source. Clock period is 10 time units, and
 reset is held high for the first 16 rising edges.
 */
module clk_gen (
   output logic clk,
   output logic reset
);

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;                      // Period 10
   end

   initial
   begin
      reset = 1'b1;
      repeat (16) @(posedge clk);
      reset <= 1'b0;                              // Released on an edge
   end

endmodule

/* bench/mbox_asserts.sv */
/*
 Link checks bound into mbox_top. A small ordering model mirrors every FIFO
 push and follows each burst, so every link handshake is compared with it.
 */
`include "mbox_config.svh"

module mbox_asserts (
   input logic                 clk,
   input logic                 reset,
   input logic                 fifo_wr_en,
   input logic [`MBOX_DW-1:0]  fifo_wr_data,
   input logic                 fifo_rd_en,
   input logic                 fifo_empty,
   input logic                 start,
   input mbox_pkg::burst_cmd_t cmd,
   input logic                 busy,
   input mbox_pkg::link_word_t link,
   input logic                 link_valid,
   input logic                 link_ready
);
   import mbox_pkg::*;

   logic [`MBOX_DW-1:0] model [0:63];             // Pushed words in order
   logic [5:0]          wr_ptr;
   logic [5:0]          pop_ptr;                  // Model head of the FIFO
   logic [5:0]          rd_ptr;                   // Oldest word not yet sent
   logic [5:0]          burst_len;
   logic [7:0]          burst_gap;
   logic [5:0]          sent;                     // Words sent in this burst
   logic [7:0]          gap_req;                  // Idle owed before next word
   logic [8:0]          low_cycles;               // Valid-low edges since handshake
   logic [`MBOX_DW-1:0] exp_data;
   logic                exp_last;
   logic                handshake;
   int                  error_count = 0;

   assign handshake = link_valid & link_ready;
   assign exp_data  = model[rd_ptr];
   assign exp_last  = (sent + 6'd1 == burst_len);

   always @(posedge clk)
   begin
      if (reset)
      begin
         wr_ptr     <= '0;
         pop_ptr    <= '0;
         rd_ptr     <= '0;
         burst_len  <= '0;
         burst_gap  <= '0;
         sent       <= '0;
         gap_req    <= '0;
         low_cycles <= '0;
      end
      else
      begin
         if (fifo_wr_en)                          // Only accepted pushes
         begin
            model[wr_ptr] <= fifo_wr_data;
            wr_ptr        <= wr_ptr + 6'd1;
         end
         if (fifo_rd_en)
            pop_ptr <= pop_ptr + 6'd1;
         if (start)
         begin
            burst_len <= cmd.len;
            burst_gap <= cmd.gap;
            sent      <= '0;
            gap_req   <= '0;                      // First word has no gap
         end
         if (handshake)
         begin
            rd_ptr     <= rd_ptr + 6'd1;
            sent       <= sent + 6'd1;
            gap_req    <= link.last ? 8'd0 : burst_gap;
            low_cycles <= '0;
         end
         else if (!link_valid && low_cycles != 9'h1ff)
            low_cycles <= low_cycles + 9'd1;      // Saturating
      end
   end

   // Word order against the pushes
   assert property (@(posedge clk) disable iff (reset)
      handshake |-> rd_ptr != wr_ptr && link.data == exp_data)
   else
   begin
      error_count++;
      $error("Mismatch link.data got %h expected %h", $sampled(link.data), $sampled(exp_data));
   end

   // Last only on the len-th word
   assert property (@(posedge clk) disable iff (reset) handshake |-> link.last == exp_last)
   else
   begin
      error_count++;
      $error("Mismatch link.last got %h expected %h", $sampled(link.last), $sampled(exp_last));
   end

   // Hold under back-pressure
   assert property (@(posedge clk) disable iff (reset)
      link_valid && !link_ready |=> link_valid && $stable(link))
   else
   begin
      error_count++;
      $error("Link word or valid changed before the handshake");
   end

   // Idle interval between words
   assert property (@(posedge clk) disable iff (reset)
      $rose(link_valid) |-> low_cycles >= {1'b0, gap_req})
   else
   begin
      error_count++;
      $error("Link valid rose after %0d idle cycles, gap needs %0d",
             $sampled(low_cycles), $sampled(gap_req));
   end

   // Pops only against words the model holds
   assert property (@(posedge clk) disable iff (reset) fifo_rd_en |-> pop_ptr != wr_ptr)
   else
   begin
      error_count++;
      $error("Sequencer popped an empty FIFO");
   end

   // Empty flag follows the model occupancy
   assert property (@(posedge clk) disable iff (reset) fifo_empty == (pop_ptr == wr_ptr))
   else
   begin
      error_count++;
      $error("Mismatch fifo_empty got %h expected %h",
             $sampled(fifo_empty), $sampled(pop_ptr == wr_ptr));
   end

   assert property (@(posedge clk) disable iff (reset) handshake && link.last |=> !busy)
   else
   begin
      error_count++;
      $error("Busy still set after the last word");
   end

   // A new burst only starts from idle
   assert property (@(posedge clk) disable iff (reset) start |-> !busy)
   else
   begin
      error_count++;
      $error("Burst start accepted while a burst was running");
   end

endmodule

bind mbox_top mbox_asserts mbox_asserts_i (
   .clk          (clk),
   .reset        (reset),
   .fifo_wr_en   (fifo_wr_en),
   .fifo_wr_data (fifo_wr_data),
   .fifo_rd_en   (fifo_rd_en),
   .fifo_empty   (fifo_empty),
   .start        (start),
   .cmd          (cmd),
   .busy         (busy),
   .link         (link),
   .link_valid   (link_valid),
   .link_ready   (link_ready)
);

/* bench/mbox_tb.sv */
/*
 Top-level testbench for the link transmitter. Fills the FIFO over APB,
 runs bursts against a random link ready and exercises the refusal cases.
 Link checking lives in the bound assertion module.
 */
`include "mbox_config.svh"

module mbox_tb;
   import mbox_pkg::*;

   localparam int NUM_BURSTS = 6;
   localparam int MAX_GAP    = 3;
   localparam int MAX_STALL  = 32;                // Longest ready-low run allowed for
   localparam int WATCHDOG_CYCLES = NUM_BURSTS * 32 * (MAX_GAP + MAX_STALL + 8) + 2000;

   logic        clk;
   logic        reset;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [7:0]  paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;
   link_word_t  link;
   logic        link_valid;
   logic        link_ready;
   integer      seed = 8;
   logic [31:0] ready_rnd;
   logic [31:0] rd;
   logic        err;
   int          check_errors = 0;
   int          assert_errors;

   clk_gen clk_gen_i (
      .clk   (clk),
      .reset (reset)
   );

   mbox_top mbox_top_i (
      .clk        (clk),
      .reset      (reset),
      .psel       (psel),
      .penable    (penable),
      .pwrite     (pwrite),
      .paddr      (paddr),
      .pwdata     (pwdata),
      .prdata     (prdata),
      .pready     (pready),
      .pslverr    (pslverr),
      .link       (link),
      .link_valid (link_valid),
      .link_ready (link_ready)
   );

   // Random back-pressure on the link
   always @(posedge clk)
   begin
      ready_rnd = $random(seed);
      if (!reset)
         link_ready <= ready_rnd[0];
   end

   task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp)
      else
      begin
         check_errors++;
         $display("Mismatch %s got %h expected %h", name, got, exp);
      end
   endtask

   // Setup, access, then idle; response sampled mid access phase
   task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic slverr);
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b1;
      paddr   <= addr;
      pwdata  <= data;
      @(posedge clk);
      penable <= 1'b1;
      @(negedge clk);
      slverr = pslverr;
      check_value("pready", {31'd0, pready}, 32'd1);
      @(posedge clk);                             // Access edge
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      paddr   <= addr;
      @(posedge clk);
      penable <= 1'b1;
      @(negedge clk);
      data = prdata;
      check_value("pready", {31'd0, pready}, 32'd1);
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic push_words(input logic [5:0] n);
      int          i;
      logic [31:0] word;
      logic        slverr;
      for (i = 0; i < int'(n); i++)
      begin
         word = $random(seed);
         apb_write(`MBOX_REG_DATA, {16'h0, word[15:0]}, slverr);
         check_value("pslverr", {31'd0, slverr}, 32'd0);
      end
   endtask

   task automatic start_burst(input logic [5:0] len, input logic [7:0] gap);
      logic slverr;
      apb_write(`MBOX_REG_CTRL, {16'h0, gap, 2'b00, len}, slverr);
      check_value("pslverr", {31'd0, slverr}, 32'd0);
   endtask

   // Poll STATUS until busy clears, bounded by the watchdog
   task automatic wait_idle();
      logic [31:0] status;
      apb_read(`MBOX_REG_STATUS, status);
      while (status[0])
         apb_read(`MBOX_REG_STATUS, status);
   endtask

   task automatic run_burst(input logic [5:0] len, input logic [7:0] gap);
      push_words(len);
      start_burst(len, gap);
      wait_idle();
   endtask

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("Test FAILED");
      $finish;
   end

   initial
   begin
      psel       <= 1'b0;
      penable    <= 1'b0;
      pwrite     <= 1'b0;
      paddr      <= 8'h00;
      pwdata     <= 32'h0;
      link_ready <= 1'b0;
      @(negedge reset);
      @(posedge clk);

      apb_read(`MBOX_REG_DATA, rd);               // DATA reads as zero
      check_value("prdata", rd, 32'h0);
      run_burst(6'd1, 8'd0);
      run_burst(6'd4, 8'd0);
      run_burst(6'd5, 8'd3);
      run_burst(6'd8, 8'd1);

      // Full FIFO, the 33rd word is dropped
      push_words(6'd32);
      apb_write(`MBOX_REG_DATA, 32'h0000_dead, err);
      check_value("pslverr", {31'd0, err}, 32'd1);
      apb_read(`MBOX_REG_STATUS, rd);
      check_value("prdata", rd, 32'h2);           // Full, not busy
      start_burst(6'd32, 8'd2);
      wait_idle();

      // Starved burst of 5 with 2 queued, polled until the FIFO drains
      push_words(6'd2);
      start_burst(6'd5, 8'd1);
      apb_read(`MBOX_REG_STATUS, rd);
      while (!rd[2])
         apb_read(`MBOX_REG_STATUS, rd);
      check_value("prdata", rd, 32'h5);           // Empty and busy
      apb_write(`MBOX_REG_CTRL, {16'h0, 8'd0, 2'b00, 6'd3}, err);
      check_value("pslverr", {31'd0, err}, 32'd1);
      push_words(6'd3);
      wait_idle();

      // Illegal lengths from idle
      apb_write(`MBOX_REG_CTRL, 32'h0000_0000, err);
      check_value("pslverr", {31'd0, err}, 32'd1);
      apb_write(`MBOX_REG_CTRL, 32'h0000_0021, err);
      check_value("pslverr", {31'd0, err}, 32'd1);
      apb_read(`MBOX_REG_STATUS, rd);
      check_value("prdata", rd, 32'h4);           // Empty, nothing started
      repeat (5) @(posedge clk);

      assert_errors = mbox_top_i.mbox_asserts_i.error_count;
      $display("Errors: %0d check, %0d assertion", check_errors, assert_errors);
      if (check_errors == 0 && assert_errors == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

/* compile.f */
+incdir+include
hdl/mbox_pkg.sv
hdl/fifo_sync.sv
hdl/mbox_regs.sv
hdl/tx_gap_timer.sv
hdl/tx_sequencer.sv
hdl/mbox_top.sv
bench/clk_gen.sv
bench/mbox_asserts.sv
bench/mbox_tb.sv

/* Makefile */
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run mbox_tb and check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"

test:
	verilator --binary --timing --assert -f compile.f --top-module mbox_tb -o mbox_sim
	./obj_dir/mbox_sim +verilator+error+limit+1000 > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "Test OK" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
